// ==== source/obj_pkg.sv ====
package obj_pkg;

    // Object table geometry
    localparam int obj_count = 128;
    localparam int obj_words = 4;
    localparam int obj_iw    = $clog2(obj_count);
    localparam int word_iw   = $clog2(obj_words);
    localparam int tbl_aw    = obj_iw + word_iw;

    // Graphics ROM and line sizes
    localparam int rom_aw    = 18;
    localparam int line_w    = 9;
    localparam int visible_w = 320;

    // Table word 0
    typedef struct packed {
        logic       last;
        logic [5:0] rsvd;
        logic [8:0] ypos;
    } tbl_w0_t;

    // Table word 1, wmo is the width in words minus one
    typedef struct packed {
        logic [5:0] rsvd;
        logic [1:0] wmo;
        logic [7:0] height;
    } tbl_w1_t;

    // Table word 2
    typedef struct packed {
        logic [1:0] rsvd;
        logic [3:0] pal;
        logic       hflip;
        logic [8:0] xpos;
    } tbl_w2_t;

    // Color 0 is transparent
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] color;
    } pxl_t;

    typedef struct packed {
        logic [8:0]        xpos;
        logic              hflip;
        logic [3:0]        pal;
        logic [1:0]        width;
        logic [rom_aw-1:0] rom_row_addr;
        logic [6:0]        spare;
    } draw_cmd_t;

endpackage

// ==== source/obj_table_ram.sv ====
`timescale 1ns/10ps

module obj_table_ram import obj_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // CPU side, always on the back bank
    input  logic              cpu_cs,
    input  logic              cpu_we,
    input  logic [tbl_aw-1:0] cpu_addr,
    input  logic [15:0]       cpu_wdata,
    output logic [15:0]       cpu_rdata,
    input  logic              swap,
    // Scanner side, always on the front bank
    input  logic [tbl_aw-1:0] tbl_addr,
    output logic [15:0]       tbl_data
);

    // Both banks in one array, the bank is the top address bit
    logic [15:0] mem [0:2*obj_count*obj_words-1];
    logic        front;
    logic        back;

    assign back = ~front;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            front <= 1'b0;
        end else if (swap) begin
            front <= ~front;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_cs && cpu_we) begin
            mem[{back, cpu_addr}] <= cpu_wdata;
        end
        if (cpu_cs && !cpu_we) begin
            cpu_rdata <= mem[{back, cpu_addr}];
        end
    end

    // Scan read port, data one cycle after the address
    always_ff @(posedge clk) begin
        tbl_data <= mem[{front, tbl_addr}];
    end

endmodule

// ==== source/obj_scan.sv ====
`timescale 1ns/10ps

module obj_scan import obj_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hstart,
    input  logic [8:0]        vrender,
    // Table read port
    output logic [tbl_aw-1:0] tbl_addr,
    input  logic [15:0]       tbl_data,
    // Draw commands
    output draw_cmd_t         cmd,
    output logic              cmd_valid,
    input  logic              cmd_ready,
    input  logic              draw_busy,
    output logic              ln_done
);

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_eval,
        st_offer,
        st_next,
        st_done
    } state_t;

    state_t            state;
    logic [obj_iw-1:0] idx;
    logic [word_iw:0]  rcnt;
    logic [8:0]        vline;
    logic [15:0]       words [0:obj_words-1];

    tbl_w0_t           w0;
    tbl_w1_t           w1;
    tbl_w2_t           w2;
    logic [8:0]        row;
    logic [2:0]        wcount;
    logic              visible;
    logic [rom_aw-1:0] row_addr;

    // rcnt runs one ahead of the word being captured
    assign tbl_addr = {idx, rcnt[word_iw-1:0]};

    assign w0 = tbl_w0_t'(words[0]);
    assign w1 = tbl_w1_t'(words[1]);
    assign w2 = tbl_w2_t'(words[2]);

    // Row inside the object, wraps modulo 512
    assign row      = vline - w0.ypos;
    assign visible  = row < {1'b0, w1.height};
    assign wcount   = {1'b0, w1.wmo} + 3'd1;
    assign row_addr = {words[3], 2'b00} + rom_aw'(row) * rom_aw'(wcount);

    always_ff @(posedge clk) begin
        if (state == st_read && rcnt != '0) begin
            words[word_iw'(rcnt - 1'b1)] <= tbl_data;
        end
        if (hstart) begin
            vline <= vrender;
        end
        if (state == st_eval) begin
            cmd.xpos         <= w2.xpos;
            cmd.hflip        <= w2.hflip;
            cmd.pal          <= w2.pal;
            cmd.width        <= w1.wmo;
            cmd.rom_row_addr <= row_addr;
            cmd.spare        <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            idx       <= '0;
            rcnt      <= '0;
            cmd_valid <= 1'b0;
            ln_done   <= 1'b0;
        end else if (hstart) begin
            state     <= st_read;
            idx       <= '0;
            rcnt      <= '0;
            cmd_valid <= 1'b0;
            ln_done   <= 1'b0;
        end else begin
            case (state)
                st_read: begin
                    rcnt <= rcnt + 1'b1;
                    if (rcnt == obj_words) begin
                        state <= st_eval;
                    end
                end
                st_eval: begin
                    if (w0.last) begin
                        state <= st_done;
                    end else if (visible) begin
                        cmd_valid <= 1'b1;
                        state     <= st_offer;
                    end else begin
                        state <= st_next;
                    end
                end
                st_offer: begin
                    if (cmd_ready) begin
                        cmd_valid <= 1'b0;
                        state     <= st_next;
                    end
                end
                st_next: begin
                    if (idx == obj_iw'(obj_count - 1)) begin
                        state <= st_done;
                    end else begin
                        idx   <= idx + 1'b1;
                        rcnt  <= '0;
                        state <= st_read;
                    end
                end
                st_done: begin
                    // Held until the next line start
                    if (!draw_busy) begin
                        ln_done <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== source/obj_draw.sv ====
`timescale 1ns/10ps

module obj_draw import obj_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // From the scanner
    input  draw_cmd_t         cmd,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    output logic              draw_busy,
    // Graphics ROM
    output logic              obj_cs,
    output logic [rom_aw-1:0] obj_addr,
    input  logic              obj_ok,
    input  logic [31:0]       obj_data,
    // Line buffer write
    output logic              buf_we,
    output logic [line_w-1:0] buf_addr,
    output pxl_t              buf_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_write
    } state_t;

    state_t      state;
    draw_cmd_t   cur;
    logic [31:0] pattern;
    logic [1:0]  wcnt;
    logic [2:0]  pcnt;
    logic [4:0]  pos;
    logic [4:0]  off;
    logic [3:0]  color;

    assign cmd_ready = state == st_idle;
    // The last pixel write still counts as busy
    assign draw_busy = state != st_idle || buf_we;

    // Pixel position inside the object
    assign pos = {wcnt, pcnt};
    // Mirror across the whole object width, not the word
    assign off = cur.hflip ? {cur.width, 3'b111} - pos : pos;
    // Lowest nibble is the leftmost pixel
    assign color = pattern[{pcnt, 2'b00} +: 4];

    always_ff @(posedge clk) begin
        if (state == st_idle && cmd_valid) begin
            cur <= cmd;
        end
        if (state == st_fetch && obj_ok) begin
            pattern <= obj_data;
        end
        if (state == st_write) begin
            buf_addr       <= cur.xpos + line_w'(off);
            buf_data.pal   <= cur.pal;
            buf_data.color <= color;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            obj_cs   <= 1'b0;
            obj_addr <= '0;
            buf_we   <= 1'b0;
            wcnt     <= '0;
            pcnt     <= '0;
        end else begin
            buf_we <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd_valid) begin
                        obj_addr <= cmd.rom_row_addr;
                        obj_cs   <= 1'b1;
                        wcnt     <= '0;
                        state    <= st_fetch;
                    end
                end
                st_fetch: begin
                    // Address held until the acknowledge
                    if (obj_ok) begin
                        obj_cs <= 1'b0;
                        pcnt   <= '0;
                        state  <= st_write;
                    end
                end
                st_write: begin
                    // Transparent pixels leave the buffer alone
                    buf_we <= color != 4'd0;
                    pcnt   <= pcnt + 1'b1;
                    if (pcnt == 3'd7) begin
                        if (wcnt == cur.width) begin
                            state <= st_idle;
                        end else begin
                            wcnt     <= wcnt + 1'b1;
                            obj_addr <= obj_addr + 1'b1;
                            obj_cs   <= 1'b1;
                            state    <= st_fetch;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== source/obj_line_buf.sv ====
`timescale 1ns/10ps

module obj_line_buf import obj_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hstart,
    input  logic              lhbl,
    input  logic              pxl_cen,
    // Drawer side
    input  logic              we,
    input  logic [line_w-1:0] wr_addr,
    input  pxl_t              wr_data,
    // Video side
    output pxl_t              pxl
);

    pxl_t              half_a [0:2**line_w-1];
    pxl_t              half_b [0:2**line_w-1];
    logic              draw_b;
    logic [line_w-1:0] rd_cnt;
    logic              rd;
    pxl_t              rd_q;

    // Both halves start empty
    initial begin
        for (int i = 0; i < 2**line_w; i++) begin
            half_a[i] = '0;
            half_b[i] = '0;
        end
    end

    assign rd  = pxl_cen && lhbl && rd_cnt < visible_w;
    assign pxl = lhbl ? rd_q : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            draw_b <= 1'b0;
            rd_cnt <= '0;
        end else begin
            if (hstart) begin
                draw_b <= ~draw_b;
            end
            if (!lhbl) begin
                rd_cnt <= '0;
            end else if (rd) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // Each half has one writer at a time, the drawer or the eraser
    always_ff @(posedge clk) begin
        if (draw_b) begin
            if (we) half_b[wr_addr] <= wr_data;
            if (rd) half_a[rd_cnt] <= '0;
        end else begin
            if (we) half_a[wr_addr] <= wr_data;
            if (rd) half_b[rd_cnt] <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!lhbl) begin
            rd_q <= '0;
        end else if (rd) begin
            rd_q <= draw_b ? half_a[rd_cnt] : half_b[rd_cnt];
        end
    end

endmodule

// ==== source/obj_engine.sv ====
`timescale 1ns/10ps

module obj_engine import obj_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // CPU port
    input  logic              cpu_cs,
    input  logic              cpu_we,
    input  logic [tbl_aw-1:0] cpu_addr,
    input  logic [15:0]       cpu_wdata,
    output logic [15:0]       cpu_rdata,
    input  logic              obj_swap,
    // Graphics ROM
    output logic              obj_cs,
    output logic [rom_aw-1:0] obj_addr,
    input  logic              obj_ok,
    input  logic [31:0]       obj_data,
    // Video timing
    input  logic              pxl_cen,
    input  logic              lhbl,
    input  logic              hstart,
    input  logic [8:0]        vrender,
    output pxl_t              pxl,
    output logic              ln_done
);

    logic [tbl_aw-1:0] tbl_addr;
    logic [15:0]       tbl_data;

    draw_cmd_t         cmd;
    logic              cmd_valid;
    logic              cmd_ready;
    logic              draw_busy;

    logic              buf_we;
    logic [line_w-1:0] buf_addr;
    pxl_t              buf_data;

    obj_table_ram u_table (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cpu_cs    ( cpu_cs    ),
        .cpu_we    ( cpu_we    ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_wdata ( cpu_wdata ),
        .cpu_rdata ( cpu_rdata ),
        .swap      ( obj_swap  ),
        .tbl_addr  ( tbl_addr  ),
        .tbl_data  ( tbl_data  )
    );

    obj_scan u_scan (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .hstart    ( hstart    ),
        .vrender   ( vrender   ),
        .tbl_addr  ( tbl_addr  ),
        .tbl_data  ( tbl_data  ),
        .cmd       ( cmd       ),
        .cmd_valid ( cmd_valid ),
        .cmd_ready ( cmd_ready ),
        .draw_busy ( draw_busy ),
        .ln_done   ( ln_done   )
    );

    obj_draw u_draw (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cmd       ( cmd       ),
        .cmd_valid ( cmd_valid ),
        .cmd_ready ( cmd_ready ),
        .draw_busy ( draw_busy ),
        .obj_cs    ( obj_cs    ),
        .obj_addr  ( obj_addr  ),
        .obj_ok    ( obj_ok    ),
        .obj_data  ( obj_data  ),
        .buf_we    ( buf_we    ),
        .buf_addr  ( buf_addr  ),
        .buf_data  ( buf_data  )
    );

    obj_line_buf u_line (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .hstart    ( hstart    ),
        .lhbl      ( lhbl      ),
        .pxl_cen   ( pxl_cen   ),
        .we        ( buf_we    ),
        .wr_addr   ( buf_addr  ),
        .wr_data   ( buf_data  ),
        .pxl       ( pxl       )
    );

endmodule

// ==== bench/obj_engine_tb.sv ====
`timescale 1ns/10ps

module obj_engine_tb import obj_pkg::*; ();

    logic              clk;
    logic              rst_n;
    logic              cpu_cs;
    logic              cpu_we;
    logic [tbl_aw-1:0] cpu_addr;
    logic [15:0]       cpu_wdata;
    logic [15:0]       cpu_rdata;
    logic              obj_swap;
    logic              obj_cs;
    logic [rom_aw-1:0] obj_addr;
    logic              obj_ok;
    logic [31:0]       obj_data;
    logic              pxl_cen;
    logic              lhbl;
    logic              hstart;
    logic [8:0]        vrender;
    pxl_t              pxl;
    logic              ln_done;

    integer            seed;
    integer            rom_seed;
    bit                slow_rom;
    logic              shown_bank;
    int                lines_run;
    int                err_pxl;
    int                err_cpu;
    int                err_done;
    int                err_rom;
    // Testbench view of both table banks
    logic [15:0]       table_copy [0:1][0:obj_count*obj_words-1];
    logic [7:0]        cur_exp [0:visible_w-1];
    logic [7:0]        next_exp [0:visible_w-1];

    obj_engine UUT (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cpu_cs    ( cpu_cs    ),
        .cpu_we    ( cpu_we    ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_wdata ( cpu_wdata ),
        .cpu_rdata ( cpu_rdata ),
        .obj_swap  ( obj_swap  ),
        .obj_cs    ( obj_cs    ),
        .obj_addr  ( obj_addr  ),
        .obj_ok    ( obj_ok    ),
        .obj_data  ( obj_data  ),
        .pxl_cen   ( pxl_cen   ),
        .lhbl      ( lhbl      ),
        .hstart    ( hstart    ),
        .vrender   ( vrender   ),
        .pxl       ( pxl       ),
        .ln_done   ( ln_done   )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Pattern word as a fixed hash of the address with small nibbles made transparent
    function automatic logic [31:0] rom_word(input logic [rom_aw-1:0] addr);
        logic [31:0] h;
        h = {14'd0, addr} * 32'h9e37_79b1;
        h = h ^ (h >> 15) ^ 32'h2c1b_3c6d;
        for (int i = 0; i < 8; i++) begin
            if (h[i*4 +: 4] < 4'd4) begin
                h[i*4 +: 4] = 4'd0;
            end
        end
        return h;
    endfunction

    // Expected pixel at screen position x for line v where later objects win
    function automatic logic [7:0] ref_pixel(input logic bank, input logic [8:0] v,
                                             input int x);
        logic [7:0]        result;
        logic [15:0]       w0;
        logic [15:0]       w1;
        logic [15:0]       w2;
        logic [15:0]       w3;
        logic [8:0]        row;
        logic [8:0]        off;
        logic [8:0]        span;
        logic [8:0]        px;
        logic [rom_aw-1:0] addr;
        logic [31:0]       pat;
        logic [3:0]        color;
        result = 8'h00;
        for (int i = 0; i < obj_count; i++) begin
            w0 = table_copy[bank][i*4];
            w1 = table_copy[bank][i*4+1];
            w2 = table_copy[bank][i*4+2];
            w3 = table_copy[bank][i*4+3];
            if (w0[15]) begin
                break;
            end
            row  = v - w0[8:0];
            off  = 9'(x) - w2[8:0];
            span = {3'd0, w1[9:8] + 3'd1, 3'd0};
            if (row < {1'b0, w1[7:0]} && off < span) begin
                // Mirror spans the whole object
                px    = w2[9] ? span - 9'd1 - off : off;
                addr  = {w3, 2'b00} + 18'(row) * 18'(w1[9:8] + 3'd1) + 18'(px[8:3]);
                pat   = rom_word(addr);
                color = pat[{px[2:0], 2'b00} +: 4];
                if (color != 4'd0) begin
                    result = {w2[13:10], color};
                end
            end
        end
        return result;
    endfunction

    task automatic cpu_write(input logic [8:0] addr, input logic [15:0] data);
        cpu_cs    = 1'b1;
        cpu_we    = 1'b1;
        cpu_addr  = addr;
        cpu_wdata = data;
        @(posedge clk);
        #10;
        cpu_cs = 1'b0;
        cpu_we = 1'b0;
        table_copy[!shown_bank][addr] = data;
    endtask

    task automatic cpu_read_check(input logic [8:0] addr);
        cpu_cs   = 1'b1;
        cpu_we   = 1'b0;
        cpu_addr = addr;
        @(posedge clk);
        #10;
        cpu_cs = 1'b0;
        if (cpu_rdata !== table_copy[!shown_bank][addr]) begin
            err_cpu++;
            $display("ERR %0t cpu_rdata[%h]: got %h expected %h", $time, addr, cpu_rdata,
                     table_copy[!shown_bank][addr]);
        end
    endtask

    task automatic put_object(input int idx, input logic [8:0] ypos, input logic [7:0] height,
                              input logic [1:0] wmo, input logic [8:0] xpos, input logic hflip,
                              input logic [3:0] pal, input logic [15:0] base);
        cpu_write(9'(idx*4), {7'd0, ypos});
        cpu_write(9'(idx*4 + 1), {6'd0, wmo, height});
        cpu_write(9'(idx*4 + 2), {2'd0, pal, hflip, xpos});
        cpu_write(9'(idx*4 + 3), base);
    endtask

    task automatic end_list(input int idx);
        cpu_write(9'(idx*4), 16'h8000);
        cpu_write(9'(idx*4 + 1), 16'h0000);
        cpu_write(9'(idx*4 + 2), 16'h0000);
        cpu_write(9'(idx*4 + 3), 16'h0000);
    endtask

    // Objects with tops between ybase and ybase+31
    task automatic load_random_table(input int n, input logic [8:0] ybase, input bit wide);
        logic [31:0] r;
        logic [31:0] b;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            b = $random(seed);
            put_object(i, ybase + 9'(r[4:0]), 8'd8 + 8'(r[10:5]), wide ? 2'd3 : r[12:11],
                       r[21:13], r[22], r[26:23], b[15:0]);
        end
        end_list(n);
    endtask

    task automatic load_overlap_table;
        put_object(0, 9'd190, 8'd40, 2'd3, 9'd40, 1'b0, 4'd1, 16'h0100);
        put_object(1, 9'd195, 8'd20, 2'd1, 9'd50, 1'b1, 4'd2, 16'h0200);
        put_object(2, 9'd200, 8'd8, 2'd3, 9'd60, 1'b1, 4'd3, 16'h0300);
        // These two wrap past position 511
        put_object(3, 9'd180, 8'd30, 2'd2, 9'd500, 1'b0, 4'd4, 16'h0400);
        put_object(4, 9'd198, 8'd10, 2'd3, 9'd496, 1'b1, 4'd5, 16'h0500);
        put_object(5, 9'd150, 8'd10, 2'd3, 9'd100, 1'b0, 4'd6, 16'h0600);
        end_list(6);
    endtask

    task automatic wait_ln_done;
        int n;
        n = 0;
        while (ln_done !== 1'b1 && n < 5000) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (ln_done !== 1'b1) begin
            $display("Timeout, ln_done stayed low for %0d cycles", n);
            $display("test failed");
            $finish;
        end
    endtask

    // Swap only once the current scan is over
    task automatic swap_banks;
        if (lines_run > 0) begin
            wait_ln_done();
        end
        obj_swap = 1'b1;
        @(posedge clk);
        #10;
        obj_swap   = 1'b0;
        shown_bank = !shown_bank;
    endtask

    // One video line of hstart, blank and 320 active pixels
    task automatic run_line(input logic [8:0] v);
        for (int x = 0; x < visible_w; x++) begin
            cur_exp[x]  = next_exp[x];
            next_exp[x] = ref_pixel(shown_bank, v, x);
        end
        hstart  = 1'b1;
        vrender = v;
        @(posedge clk);
        #10;
        hstart = 1'b0;
        repeat (1200) begin
            @(posedge clk);
            #10;
        end
        lhbl = 1'b1;
        for (int x = 0; x < 2*visible_w; x++) begin
            pxl_cen = (x % 2 == 0);
            @(posedge clk);
            #10;
        end
        pxl_cen = 1'b0;
        lhbl    = 1'b0;
        @(posedge clk);
        #10;
        if (ln_done !== 1'b1) begin
            err_done++;
            $display("ERR %0t ln_done: got %b expected 1", $time, ln_done);
        end
        lines_run++;
    endtask

    // Graphics ROM with 1 to 4 cycles of latency
    initial begin : rom_model
        int                remain;
        logic [31:0]       r;
        logic [rom_aw-1:0] req_addr;
        remain   = 0;
        req_addr = '0;
        forever begin
            @(posedge clk);
            #10;
            if (obj_ok) begin
                obj_ok = 1'b0;
                // Request drops right after the acknowledge
                if (obj_cs !== 1'b0) begin
                    err_rom++;
                    $display("ERR %0t obj_cs: got %b expected 0", $time, obj_cs);
                end
            end else if (obj_cs) begin
                if (remain == 0) begin
                    r        = $random(rom_seed);
                    remain   = slow_rom ? 4 : 1 + int'(r[1:0]);
                    req_addr = obj_addr;
                end else if (obj_addr !== req_addr) begin
                    err_rom++;
                    $display("ERR %0t obj_addr: got %h expected %h", $time, obj_addr,
                             req_addr);
                end
                remain--;
                if (remain == 0) begin
                    obj_ok   = 1'b1;
                    obj_data = rom_word(obj_addr);
                end
            end
        end
    end

    // Pixel checker samples pxl at the falling edge
    initial begin : compare_pixels
        int   col;
        logic active;
        col = 0;
        forever begin
            @(posedge clk);
            active = pxl_cen && lhbl;
            if (!lhbl) begin
                col = 0;
            end
            @(negedge clk);
            if (active) begin
                if (pxl !== cur_exp[col]) begin
                    err_pxl++;
                    $display("ERR %0t pxl[%0d]: got %h expected %h", $time, col, pxl,
                             cur_exp[col]);
                end
                col++;
            end else if (!lhbl && pxl !== 8'h00) begin
                err_pxl++;
                $display("ERR %0t pxl (blank): got %h expected 00", $time, pxl);
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [8:0]  wr_list [0:31];
        seed       = 32'h6fc7_0fbe;
        rom_seed   = 32'h6fc7_0fbe;
        slow_rom   = 1'b0;
        shown_bank = 1'b0;
        lines_run  = 0;
        err_pxl    = 0;
        err_cpu    = 0;
        err_done   = 0;
        err_rom    = 0;
        rst_n      = 1'b0;
        cpu_cs     = 1'b0;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        obj_swap   = 1'b0;
        obj_ok     = 1'b0;
        obj_data   = '0;
        pxl_cen    = 1'b0;
        lhbl       = 1'b0;
        hstart     = 1'b0;
        vrender    = '0;
        for (int x = 0; x < visible_w; x++) begin
            next_exp[x] = 8'h00;
        end
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // CPU write and readback on the back bank
        for (int i = 0; i < 32; i++) begin
            r          = $random(seed);
            wr_list[i] = 9'(i*16) + 9'(r[19:16]);
            cpu_write(wr_list[i], r[15:0]);
        end
        for (int i = 0; i < 32; i++) begin
            cpu_read_check(wr_list[i]);
        end

        // Random objects
        load_random_table(16, 9'd72, 1'b0);
        swap_banks();
        for (int v = 100; v < 105; v++) begin
            run_line(9'(v));
        end

        // Overlap, mirror and wrap
        load_overlap_table();
        swap_banks();
        for (int v = 200; v < 203; v++) begin
            run_line(9'(v));
        end

        // Back bank edits stay hidden until the swap
        load_random_table(16, 9'd176, 1'b0);
        run_line(9'd201);
        run_line(9'd202);
        swap_banks();
        for (int v = 202; v < 205; v++) begin
            run_line(9'(v));
        end

        // Slowest ROM with wide objects
        slow_rom = 1'b1;
        load_random_table(16, 9'd40, 1'b1);
        swap_banks();
        for (int v = 60; v < 64; v++) begin
            run_line(9'(v));
        end

        // Empty table after a busy line
        end_list(0);
        swap_banks();
        for (int v = 64; v < 67; v++) begin
            run_line(9'(v));
        end

        $display("Errors: pxl %0d, cpu_rdata %0d, ln_done %0d, rom %0d", err_pxl, err_cpu,
                 err_done, err_rom);
        if (err_pxl + err_cpu + err_done + err_rom == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
source/obj_pkg.sv
source/obj_table_ram.sv
source/obj_scan.sv
source/obj_draw.sv
source/obj_line_buf.sv
source/obj_engine.sv
bench/obj_engine_tb.sv

// ==== Makefile ====
# Verilator build of the object engine testbench

VERILATOR ?= verilator
TOP       ?= obj_engine_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
